/* list.f */
rtl/cache_pkg.sv
rtl/cache_lookup.sv
rtl/cache_fill_fsm.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/mem_pipe.sv
rtl/cache_top.sv
tests/cache_checker.sv
tests/tb_cache.sv

/* rtl/cache_fill_fsm.sv */
// Cache block fill FSM
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                miss_detected,
    input  logic [addr_w-1:0]   miss_address,
    input  logic                mem_data_valid,
    output logic                fill_busy,
    output logic                mem_rd,
    output logic [addr_w-1:0]   memory_address,
    output logic [offset_w-1:0] offset,
    output logic                write_data_array,
    output logic                write_tag_array
);

    localparam logic [offset_w-1:0] last_offset = offset_w'(block_words - 1);

    // word being requested and word next to be received
    logic [offset_w-1:0] request;
    logic [offset_w-1:0] receive;

    logic mem_rd_next;
    logic fill_busy_next;
    logic last_word;

    // requesting runs for one block, one read per cycle
    assign mem_rd_next = mem_rd ? (request != last_offset) : miss_detected;

    // busy until the eighth word has come back
    assign last_word      = write_data_array && (receive == last_offset);
    assign fill_busy_next = fill_busy ? !last_word : miss_detected;

    // reads go out back to back from the start of the block
    assign memory_address = {miss_address[addr_w-1:block_lsb], request, 1'b0};

    // data array is written only when a word arrives
    assign offset           = receive;
    assign write_data_array = mem_data_valid && fill_busy;

    // tag and valid go in with the last word
    assign write_tag_array = last_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rd    <= 1'b0;
            fill_busy <= 1'b0;
        end else begin
            mem_rd    <= mem_rd_next;
            fill_busy <= fill_busy_next;
        end
    end

    // request counter steps every requesting cycle
    // eight steps wrap it back to zero for the next miss
    always_ff @(posedge clk) begin
        if (reset) begin
            request <= '0;
        end else if (mem_rd) begin
            request <= request + 1'b1;
        end
    end

    // receive counter steps on each word written
    always_ff @(posedge clk) begin
        if (reset) begin
            receive <= '0;
        end else if (write_data_array) begin
            receive <= receive + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_lookup.sv */
// Cache lookup stage
`timescale 1ns/1ps
`default_nettype none

module cache_lookup import cache_pkg::*; #(
    parameter int index_w = 6,
    localparam int tag_w = addr_w - block_lsb - index_w
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  cache_req_t          req,
    input  logic                fill_busy,
    input  logic [tag_w-1:0]    tag_q,
    input  logic                tag_valid_q,
    input  logic [word_w-1:0]   data_q,
    output logic                busy,
    output logic                resp_valid,
    output cache_resp_t         resp,
    output logic [index_w-1:0]  rd_index,
    output logic [offset_w-1:0] rd_offset,
    output logic                miss_detected,
    output logic [addr_w-1:0]   miss_address,
    output logic                hit_write,
    output logic                mem_wr,
    output logic [addr_w-1:0]   mem_waddr,
    output logic [word_w-1:0]   mem_wdata
);

    // registered request and its state
    cache_req_t req_q;
    logic       pending;
    logic       waiting;

    logic       accept;
    logic       check;
    logic       hit;
    logic       read_miss;

    // fields of the held request
    assign rd_index  = req_q.addr[block_lsb +: index_w];
    assign rd_offset = addr_offset(req_q.addr);

    // compare on the first cycle, or again once the fill has finished
    assign check     = pending && (!waiting || !fill_busy);
    assign hit       = check && tag_valid_q && (tag_q == req_q.addr[addr_w-1 -: tag_w]);
    assign read_miss = check && !hit && !req_q.wr;

    // writes always answer on their first compare, reads only on a hit
    assign resp_valid = check && (hit || req_q.wr);
    assign resp.rdata = data_q;
    assign resp.hit   = hit;

    // stall while a miss is found or its fill is running
    assign busy   = read_miss || (waiting && fill_busy);
    assign accept = req_valid && !busy;

    // fill request towards the fill state machine
    assign miss_detected = read_miss;
    assign miss_address  = req_q.addr;

    // write-through, the line only on a hit
    assign hit_write = hit && req_q.wr;
    assign mem_wr    = check && req_q.wr;
    assign mem_waddr = req_q.addr;
    assign mem_wdata = req_q.wdata;

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // request held until answered
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (resp_valid) begin
            pending <= 1'b0;
        end
    end

    // set by a read miss, cleared by the replayed answer
    always_ff @(posedge clk) begin
        if (reset) begin
            waiting <= 1'b0;
        end else if (read_miss) begin
            waiting <= 1'b1;
        end else if (resp_valid) begin
            waiting <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
// Cache shared definitions
`default_nettype none

package cache_pkg;

    // byte address and data word sizes
    localparam int addr_w = 16;
    localparam int word_w = 16;

    // eight words per block, word offset sits above the byte bit
    localparam int block_words = 8;
    localparam int offset_w = 3;
    localparam int block_lsb = offset_w + 1;

    // one request from the driver
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              wr;
        logic [word_w-1:0] wdata;
    } cache_req_t;

    // one response back to the driver
    typedef struct packed {
        logic [word_w-1:0] rdata;
        logic              hit;
    } cache_resp_t;

    // word address of a byte address
    function automatic logic [addr_w-2:0] addr_word(input logic [addr_w-1:0] addr);
        return addr[addr_w-1:1];
    endfunction

    // word offset inside the block
    function automatic logic [offset_w-1:0] addr_offset(input logic [addr_w-1:0] addr);
        return addr[block_lsb-1:1];
    endfunction

    // power-up memory image, word address xor a fixed mask
    function automatic logic [word_w-1:0] mem_init_word(input logic [addr_w-2:0] word_addr);
        return word_w'(word_addr) ^ 16'h5a5a;
    endfunction

endpackage

`default_nettype wire

/* rtl/cache_top.sv */
// Write-through cache top level
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int index_w     = 6,
    parameter int mem_latency = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  cache_req_t  req,
    output logic        busy,
    output logic        resp_valid,
    output cache_resp_t resp
);

    localparam int tag_w = addr_w - block_lsb - index_w;

    // lookup side
    logic [index_w-1:0]  rd_index;
    logic [offset_w-1:0] rd_offset;
    logic [tag_w-1:0]    tag_q;
    logic                tag_valid_q;
    logic [word_w-1:0]   data_q;
    logic                hit_write;

    // miss handling
    logic                miss_detected;
    logic [addr_w-1:0]   miss_address;
    logic                fill_busy;
    logic [offset_w-1:0] offset;
    logic                write_data_array;
    logic                write_tag_array;

    // memory buses
    logic                mem_rd;
    logic [addr_w-1:0]   memory_address;
    logic                mem_data_valid;
    logic [word_w-1:0]   mem_rdata;
    logic                mem_wr;
    logic [addr_w-1:0]   mem_waddr;
    logic [word_w-1:0]   mem_wdata;

    // set and tag of the block being filled
    logic [index_w-1:0]  fill_index;
    logic [tag_w-1:0]    fill_tag;

    assign fill_index = miss_address[block_lsb +: index_w];
    assign fill_tag   = miss_address[addr_w-1 -: tag_w];

    cache_lookup #(.index_w(index_w)) u_lookup (
        .clk, .reset, .req_valid, .req, .fill_busy,
        .tag_q, .tag_valid_q, .data_q,
        .busy, .resp_valid, .resp, .rd_index, .rd_offset,
        .miss_detected, .miss_address, .hit_write,
        .mem_wr, .mem_waddr, .mem_wdata
    );

    cache_fill_fsm u_fill (
        .clk, .reset, .miss_detected, .miss_address, .mem_data_valid,
        .fill_busy, .mem_rd, .memory_address, .offset,
        .write_data_array, .write_tag_array
    );

    tag_array #(.index_w(index_w)) u_tags (
        .clk, .reset, .rd_index,
        .wr_en    (write_tag_array),
        .wr_index (fill_index),
        .wr_tag   (fill_tag),
        .tag_q, .tag_valid_q
    );

    data_array #(.index_w(index_w)) u_data (
        .clk, .rd_index, .rd_offset,
        .fill_en     (write_data_array),
        .fill_index  (fill_index),
        .fill_offset (offset),
        .fill_data   (mem_rdata),
        .hit_write,
        .wdata       (mem_wdata),
        .data_q
    );

    mem_pipe #(.mem_latency(mem_latency)) u_mem (
        .clk, .reset, .mem_rd, .memory_address,
        .mem_wr, .mem_waddr, .mem_wdata,
        .mem_data_valid, .mem_rdata
    );

endmodule

`default_nettype wire

/* rtl/data_array.sv */
// Cache data array
`timescale 1ns/1ps
`default_nettype none

module data_array import cache_pkg::*; #(
    parameter int index_w = 6
) (
    input  logic                clk,
    input  logic [index_w-1:0]  rd_index,
    input  logic [offset_w-1:0] rd_offset,
    input  logic                fill_en,
    input  logic [index_w-1:0]  fill_index,
    input  logic [offset_w-1:0] fill_offset,
    input  logic [word_w-1:0]   fill_data,
    input  logic                hit_write,
    input  logic [word_w-1:0]   wdata,
    output logic [word_w-1:0]   data_q
);

    localparam int depth = (2 ** index_w) * block_words;

    // words addressed by set and offset together
    logic [word_w-1:0] words [depth];

    logic [index_w+offset_w-1:0] rd_addr;
    logic [index_w+offset_w-1:0] fill_addr;

    assign rd_addr   = {rd_index, rd_offset};
    assign fill_addr = {fill_index, fill_offset};

    // fill words from memory, or one word from a write hit
    // the two never overlap since hits wait for the fill to end
    always_ff @(posedge clk) begin
        if (fill_en) begin
            words[fill_addr] <= fill_data;
        end else if (hit_write) begin
            words[rd_addr] <= wdata;
        end
    end

    // word of the held request
    assign data_q = words[rd_addr];

endmodule

`default_nettype wire

/* rtl/mem_pipe.sv */
// Pipelined word memory
`timescale 1ns/1ps
`default_nettype none

module mem_pipe import cache_pkg::*; #(
    // read latency in cycles, 1 to 8
    parameter int mem_latency = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_rd,
    input  logic [addr_w-1:0] memory_address,
    input  logic              mem_wr,
    input  logic [addr_w-1:0] mem_waddr,
    input  logic [word_w-1:0] mem_wdata,
    output logic              mem_data_valid,
    output logic [word_w-1:0] mem_rdata
);

    localparam int depth = 2 ** (addr_w - 1);

    // 32K words
    logic [word_w-1:0] mem [depth];

    // read requests in flight
    logic [mem_latency-1:0] valid_pipe;
    logic [word_w-1:0]      data_pipe [mem_latency];

    // pattern image at time zero
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = mem_init_word((addr_w - 1)'(i));
        end
    end

    // write port, effective at the edge
    always @(posedge clk) begin
        if (mem_wr) begin
            mem[addr_word(mem_waddr)] <= mem_wdata;
        end
    end

    // valid flags shift one stage per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= mem_rd;
            for (int i = 1; i < mem_latency; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // word read on request, then carried along with its flag
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            data_pipe[0] <= mem[addr_word(memory_address)];
        end
        for (int i = 1; i < mem_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // last stage is the return bus
    assign mem_data_valid = valid_pipe[mem_latency-1];
    assign mem_rdata      = data_pipe[mem_latency-1];

endmodule

`default_nettype wire

/* rtl/tag_array.sv */
// Cache tag array
`timescale 1ns/1ps
`default_nettype none

module tag_array import cache_pkg::*; #(
    parameter int index_w = 6,
    localparam int tag_w = addr_w - block_lsb - index_w
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [index_w-1:0] rd_index,
    input  logic               wr_en,
    input  logic [index_w-1:0] wr_index,
    input  logic [tag_w-1:0]   wr_tag,
    output logic [tag_w-1:0]   tag_q,
    output logic               tag_valid_q
);

    localparam int sets = 2 ** index_w;

    // one tag and one valid bit per set
    logic [tag_w-1:0] tags [sets];
    logic [sets-1:0]  valid;

    // tag storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_index] <= wr_tag;
        end
    end

    // valid bits, all cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // lookup read in the same cycle
    assign tag_q       = tags[rd_index];
    assign tag_valid_q = valid[rd_index];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_cache \
    -Mdir "$build_dir" -o sim_cache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_cache" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

/* tests/cache_checker.sv */
// Fill FSM assertions
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic fill_busy,
    input wire logic mem_rd,
    input wire logic mem_data_valid,
    input wire logic write_tag_array
);

    // tag goes in at the end of a fill once all of its reads are out
    tag_in_fill: assert property (@(posedge clk) disable iff (reset)
        write_tag_array |-> (fill_busy && !mem_rd))
        else $error("tag array written outside a fill or before its reads ended");

    // memory reads only while a fill runs
    rd_in_fill: assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> fill_busy)
        else $error("memory read issued with no fill running");

    // returned words arrive only while the fill runs and so all land in the data array
    words_in_fill: assert property (@(posedge clk) disable iff (reset)
        mem_data_valid |-> fill_busy)
        else $error("memory word returned with no fill running");

endmodule

bind cache_fill_fsm cache_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .fill_busy       (fill_busy),
    .mem_rd          (mem_rd),
    .mem_data_valid  (mem_data_valid),
    .write_tag_array (write_tag_array)
);

`default_nettype wire

/* tests/tb_cache.sv */
// Cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache import cache_pkg::*; ();

    localparam int index_w     = 6;
    localparam int mem_latency = 4;
    localparam int tag_w       = 16 - 4 - index_w;
    localparam int sets        = 2 ** index_w;
    localparam int drive_delay = 10;
    // generous bound on one miss with its fill and replay
    localparam int wait_limit  = 4 * (mem_latency + 8) + 20;
    localparam logic [31:0] seed = 32'h917f_ef26;

    logic        clk;
    logic        reset;
    logic        req_valid;
    cache_req_t  req;
    logic        busy;
    logic        resp_valid;
    cache_resp_t resp;

    // reference model of the memory image and a direct-mapped tag table
    logic [15:0]      model_mem [32768];
    logic [tag_w-1:0] model_tag [sets];
    logic [sets-1:0]  model_valid;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          checks_start;
    int          errors_start;
    logic        timed_out;

    cache_top #(.index_w(index_w), .mem_latency(mem_latency)) DUT (
        .clk, .reset, .req_valid, .req, .busy, .resp_valid, .resp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // linear congruential generator
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // power-up memory word is its word address xor 5a5a
    function automatic logic [15:0] pattern_word(input logic [14:0] waddr);
        return {1'b0, waddr} ^ 16'h5a5a;
    endfunction

    // small pool of 3 tags over 4 sets so hits and evictions both happen
    function automatic logic [15:0] pick_addr();
        logic [31:0] r;
        logic [5:0]  tag;
        logic [5:0]  index;
        r = next_rand();
        tag = 6'(r[31:24] % 8'd3);
        index = {4'b0000, r[21:20]};
        return {tag, index, r[18:16], 1'b0};
    endfunction

    function automatic cache_req_t make_req(input logic [15:0] addr, input logic wr,
                                            input logic [15:0] wdata);
        cache_req_t r;
        r.addr = addr;
        r.wr = wr;
        r.wdata = wdata;
        return r;
    endfunction

    task automatic check_equal(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %s: got %h expected %h", what, got, exp);
            errors++;
        end
    endtask

    // predicted hit and data before the model state update
    task automatic model_access(input cache_req_t r, output logic exp_hit,
                                output logic [15:0] exp_data);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tg;
        logic [14:0]        waddr;
        idx = r.addr[4 +: index_w];
        tg = r.addr[15 -: tag_w];
        waddr = r.addr[15:1];
        exp_hit = model_valid[idx] && (model_tag[idx] == tg);
        exp_data = model_mem[waddr];
        if (r.wr) begin
            // write-through with no allocate
            model_mem[waddr] = r.wdata;
        end else if (!exp_hit) begin
            model_valid[idx] = 1'b1;
            model_tag[idx] = tg;
        end
    endtask

    // present a request and return just before the edge that accepts it
    task automatic send_request(input cache_req_t r);
        int waited;
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b1;
        req = r;
        waited = 0;
        @(negedge clk);
        while (busy && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("request to %h was never accepted, busy stayed high", r.addr);
            timed_out = 1'b1;
        end
    endtask

    // cycles counts from the accepting edge so a hit answers in cycle 1
    task automatic wait_response(output cache_resp_t got, output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!resp_valid && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid) begin
            $display("no response within %0d cycles", wait_limit);
            timed_out = 1'b1;
        end
        got = resp;
    endtask

    task automatic check_response(input cache_req_t r, input cache_resp_t got, input int cycles,
                                  input logic exp_hit, input logic [15:0] exp_data);
        checks++;
        if (r.wr) begin
            check_equal($sformatf("resp.hit at %h", r.addr), 16'(got.hit), 16'(exp_hit));
            assert (cycles == 1) else begin
                $display("write to %h took %0d cycles instead of one", r.addr, cycles);
                errors++;
            end
        end else begin
            // read misses are replayed so every read ends as a hit
            check_equal($sformatf("resp.hit at %h", r.addr), 16'(got.hit), 16'h0001);
            check_equal($sformatf("resp.rdata at %h", r.addr), got.rdata, exp_data);
            assert ((cycles == 1) == exp_hit) else begin
                $display("read of %h took %0d cycles but a %s was expected", r.addr, cycles,
                         exp_hit ? "hit" : "miss");
                errors++;
            end
        end
    endtask

    // one request from start to finish with its check against the model
    task automatic do_access(input cache_req_t r);
        cache_resp_t got;
        int          cycles;
        logic        exp_hit;
        logic [15:0] exp_data;
        if (timed_out) return;
        send_request(r);
        if (timed_out) return;
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b0;
        wait_response(got, cycles);
        if (timed_out) return;
        model_access(r, exp_hit, exp_data);
        check_response(r, got, cycles, exp_hit, exp_data);
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - checks_start,
                 errors - errors_start);
        checks_start = checks;
        errors_start = errors;
    endtask

    task automatic quiet_reset_test();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_equal("busy", 16'(busy), 16'h0000);
            check_equal("resp_valid", 16'(resp_valid), 16'h0000);
        end
    endtask

    // the held second request waits for the first and is then served once
    task automatic stall_test();
        cache_req_t  first;
        cache_req_t  second;
        cache_resp_t got [2];
        int          seen;
        int          accepts;
        int          cycles;
        int          extra;
        logic        exp_hit;
        logic [15:0] exp_data;
        if (timed_out) return;
        // two cold blocks in sets 50 and 51
        first = make_req(16'hc320, 1'b0, 16'h0000);
        second = make_req(16'hc336, 1'b0, 16'h0000);
        send_request(first);
        if (timed_out) return;
        @(posedge clk);
        #drive_delay;
        req = second;
        seen = 0;
        accepts = 0;
        cycles = 0;
        while (seen < 2 && cycles < 2 * wait_limit) begin
            @(negedge clk);
            cycles++;
            if (resp_valid) begin
                got[seen] = resp;
                seen++;
            end
            if (req_valid && !busy) begin
                accepts++;
                @(posedge clk);
                #drive_delay;
                req_valid = 1'b0;
            end
        end
        if (seen < 2) begin
            $display("stalled request pair got %0d of 2 responses", seen);
            timed_out = 1'b1;
            req_valid = 1'b0;
            return;
        end
        // no further answer may follow
        extra = 0;
        repeat (20) begin
            @(negedge clk);
            if (resp_valid) begin
                extra++;
            end
        end
        check_equal("accepts of held request", 16'(accepts), 16'h0001);
        check_equal("extra resp_valid", 16'(extra), 16'h0000);
        model_access(first, exp_hit, exp_data);
        check_equal("resp.rdata of first", got[0].rdata, exp_data);
        check_equal("resp.hit of first", 16'(got[0].hit), 16'h0001);
        model_access(second, exp_hit, exp_data);
        check_equal("resp.rdata of held", got[1].rdata, exp_data);
        check_equal("resp.hit of held", 16'(got[1].hit), 16'h0001);
    endtask

    initial begin
        logic [31:0] r;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        lcg_state = seed;
        checks = 0;
        errors = 0;
        checks_start = 0;
        errors_start = 0;
        timed_out = 1'b0;
        model_valid = '0;
        for (int i = 0; i < 32768; i++) begin
            model_mem[i] = pattern_word(15'(i));
        end
        repeat (3) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        quiet_reset_test();
        report_test("quiet_reset");

        // fill followed by a hit in the same block
        do_access(make_req(16'h2468, 1'b0, 16'h0000));
        do_access(make_req(16'h246e, 1'b0, 16'h0000));
        report_test("cold_read");

        for (int i = 0; i < 40; i++) begin
            do_access(make_req(pick_addr(), 1'b0, 16'h0000));
        end
        report_test("random_reads");

        // mixed writes and reads over the same pool
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            do_access(make_req(pick_addr(), r[27], r[23:8]));
        end
        report_test("writes");

        // tags 1 and 2 of set 40 evict each other
        for (int i = 0; i < 5; i++) begin
            do_access(make_req((i % 2 == 0) ? 16'h0680 : 16'h0a84, 1'b0, 16'h0000));
        end
        report_test("conflicts");

        stall_test();
        report_test("stall");

        $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
